//--- Makefile
TOP := tb_tcdm_dma

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- all.f
+incdir+common
common/tcdm_dma_pkg.sv
hw/tcdm_cmd_regs.sv
hw/tcdm_cmd_fifo.sv
hw/tcdm_cmd_unpack/tcdm_cmd_unpack.sv
hw/tcdm_dma_top.sv
dv/tb_clk_gen.sv
dv/tcdm_dma_assertions.sv
dv/tb_tcdm_dma.sv

//--- common/tcdm_dma_macros.svh
//**************************************************************************
// Field widths and queue depth of the TCDM DMA command path
// Include wherever a width or the queue depth is needed
//**************************************************************************

`ifndef TCDM_DMA_MACROS_SVH
`define TCDM_DMA_MACROS_SVH

// Byte address into the TCDM
`define TCDM_ADD_WIDTH 12

// Byte length minus one
`define TCDM_LEN_WIDTH 12

// Opcode and stream id carried on each beat
`define TCDM_OPC_WIDTH 12
`define TRANS_SID_WIDTH 2

// Beat counter, covers the longest misaligned command
`define BEAT_CNT_WIDTH 10

// Entries in the command queue
`define CMD_FIFO_DEPTH 4

`endif

//--- common/tcdm_dma_pkg.sv
//**************************************************************************
// Shared types of the DMA command path
// Command word as staged by software, and one beat per TCDM port
//**************************************************************************

`include "tcdm_dma_macros.svh"

package tcdm_dma_pkg;

  // One transfer command, as held in the register block and the queue
  typedef struct packed {
    // Operation code passed to every beat
    logic [`TCDM_OPC_WIDTH-1:0]  opc;
    // Byte count minus one
    logic [`TCDM_LEN_WIDTH-1:0]  len;
    // Start byte address, any alignment
    logic [`TCDM_ADD_WIDTH-1:0]  add;
    // Stream id
    logic [`TRANS_SID_WIDTH-1:0] sid;
  } tcdm_cmd_t;

  // One 32-bit port beat, two of them form a 64-bit TCDM beat
  typedef struct packed {
    logic [`TCDM_OPC_WIDTH-1:0]  opc;
    // Word address, 8-aligned on port 0 and plus 4 on port 1
    logic [`TCDM_ADD_WIDTH-1:0]  add;
    logic [`TRANS_SID_WIDTH-1:0] sid;
    // Last beat of the command
    logic                        eop;
  } tcdm_beat_t;

endpackage

//--- dv/tb_clk_gen.sv
//**************************************************************************
// Clock and reset source of the DMA testbench, 40 ns period
//**************************************************************************

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset held low for 4 cycles, released just after an edge
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

//--- dv/tb_tcdm_dma.sv
//**************************************************************************
// Testbench of the TCDM DMA command side
// LFSR driven commands and grant gaps, beats checked against a model
//**************************************************************************

`include "tcdm_dma_macros.svh"

module tb_tcdm_dma;
  timeunit 1ns;
  timeprecision 100ps;

  // Cycles any single wait may take
  localparam int unsigned wait_limit = 300;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           reg_we_i;
  logic [1:0]                     reg_addr_i;
  logic [31:0]                    reg_wdata_i;
  logic [1:0]                     beat_gnt_i;
  logic [1:0]                     beat_req_o;
  tcdm_dma_pkg::tcdm_beat_t [1:0] beat_o;
  logic                           overflow_o;
  logic                           busy_o;

  logic [31:0] lfsr_q;
  // Grants forced low so the queue fills up
  logic        gnt_hold;
  // Unpacker in the middle of a multi-beat command
  logic        exp_busy;
  // Commands pushed since the queue was last empty
  int unsigned in_flight;
  // Expected port 0 beats, oldest first
  tcdm_dma_pkg::tcdm_beat_t exp_q[$];

  tb_clk_gen u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  tcdm_dma_top u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .beat_gnt_i  (beat_gnt_i),
    .beat_req_o  (beat_req_o),
    .beat_o      (beat_o),
    .overflow_o  (overflow_o),
    .busy_o      (busy_o)
  );

  //**************************************************************************
  // Failure reporting and compares
  //**************************************************************************

  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic check_beat(input string name, input tcdm_dma_pkg::tcdm_beat_t got,
                            input tcdm_dma_pkg::tcdm_beat_t exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_req(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  //**************************************************************************
  // Stimulus
  //**************************************************************************

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic        fb;
    int unsigned i;
    val = '0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Mostly a double grant, one cycle in four a random pattern
  function automatic logic [1:0] next_gnt();
    if (rand_bits(2) == 32'd0) begin
      return 2'(rand_bits(2));
    end else begin
      return 2'b11;
    end
  endfunction

  // Beat seen at mid cycle must be the oldest one expected
  task automatic check_cycle();
    tcdm_dma_pkg::tcdm_beat_t exp0;
    tcdm_dma_pkg::tcdm_beat_t exp1;
    check_flag("busy_o", busy_o, exp_busy);
    if (beat_gnt_i != 2'b11) begin
      check_req("beat_req_o", beat_req_o, 2'b00);
    end else if (beat_req_o !== 2'b00) begin
      check_req("beat_req_o", beat_req_o, 2'b11);
      if (exp_q.size() == 0) begin
        report_problem("beat issued while no command was pending");
      end else begin
        exp0     = exp_q.pop_front();
        exp1     = exp0;
        exp1.add = exp0.add + `TCDM_ADD_WIDTH'(4);
        check_beat("beat_o[0]", beat_o[0], exp0);
        check_beat("beat_o[1]", beat_o[1], exp1);
        // Busy from the first beat until the last one is out
        exp_busy = !exp0.eop;
      end
    end
  endtask

  // One clock cycle, inputs 2 ns after the edge, outputs checked at the falling edge
  task automatic tick(input logic we, input logic [1:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    #2;
    reg_we_i    = we;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    beat_gnt_i  = gnt_hold ? 2'b00 : next_gnt();
    @(negedge clk_i);
    check_cycle();
  endtask

  // Beats = ((add mod 8) + len) / 8 + 1, walking 8-aligned addresses
  task automatic add_expected(input logic [`TCDM_ADD_WIDTH-1:0] add,
                              input logic [`TCDM_LEN_WIDTH-1:0] len,
                              input logic [`TCDM_OPC_WIDTH-1:0] opc,
                              input logic [`TRANS_SID_WIDTH-1:0] sid);
    tcdm_dma_pkg::tcdm_beat_t   b;
    logic [`TCDM_ADD_WIDTH-1:0] base;
    int unsigned                nb;
    int unsigned                i;
    nb   = (int'(add[2:0]) + int'(len)) / 8 + 1;
    base = add & ~`TCDM_ADD_WIDTH'(7);
    for (i = 0; i < nb; i++) begin
      b.opc = opc;
      b.add = base + `TCDM_ADD_WIDTH'(8 * i);
      b.sid = sid;
      b.eop = (i == nb - 1);
      exp_q.push_back(b);
    end
  endtask

  // Stage a random command and write go, lengths kept below 32 bytes
  task automatic push_random();
    logic [`TCDM_ADD_WIDTH-1:0]  add;
    logic [`TCDM_LEN_WIDTH-1:0]  len;
    logic [`TCDM_OPC_WIDTH-1:0]  opc;
    logic [`TRANS_SID_WIDTH-1:0] sid;
    add = `TCDM_ADD_WIDTH'(rand_bits(`TCDM_ADD_WIDTH));
    len = `TCDM_LEN_WIDTH'(rand_bits(5));
    opc = `TCDM_OPC_WIDTH'(rand_bits(`TCDM_OPC_WIDTH));
    sid = `TRANS_SID_WIDTH'(rand_bits(`TRANS_SID_WIDTH));
    tick(1'b1, 2'd0, 32'(add));
    tick(1'b1, 2'd1, 32'(len));
    tick(1'b1, 2'd2, (32'(sid) << 16) | 32'(opc));
    tick(1'b1, 2'd3, 32'd0);
    // A full queue drops the command
    if (in_flight < `CMD_FIFO_DEPTH) begin
      in_flight++;
      add_expected(add, len, opc, sid);
    end
  endtask

  // Run until every expected beat is out and the unpacker is idle
  task automatic drain();
    int unsigned n;
    n = 0;
    while (exp_q.size() != 0) begin
      if (n >= wait_limit) begin
        report_problem("timeout: expected beats were never issued");
      end else begin
        tick(1'b0, 2'd0, 32'd0);
        n++;
      end
    end
    n = 0;
    while (busy_o !== 1'b0) begin
      if (n >= wait_limit) begin
        report_problem("timeout waiting for the unpacker to go idle");
      end else begin
        tick(1'b0, 2'd0, 32'd0);
        n++;
      end
    end
    in_flight = 0;
  endtask

  //**************************************************************************
  // Test sequence
  //**************************************************************************

  initial begin
    int unsigned n;
    int unsigned burst;
    reg_we_i    = 1'b0;
    reg_addr_i  = 2'd0;
    reg_wdata_i = 32'd0;
    beat_gnt_i  = 2'b00;
    lfsr_q      = 32'hd0dd2d39;
    gnt_hold    = 1'b0;
    exp_busy    = 1'b0;
    in_flight   = 0;

    n = 0;
    while (rst_ni !== 1'b1) begin
      if (n >= wait_limit) begin
        report_problem("timeout waiting for reset release");
      end else begin
        @(posedge clk_i);
        n++;
      end
    end

    // Quiet out of reset
    @(negedge clk_i);
    check_req("beat_req_o", beat_req_o, 2'b00);
    check_flag("overflow_o", overflow_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);

    // Bursts that fit the queue, under random grant gaps
    repeat (40) begin
      burst = rand_bits(2) + 1;
      repeat (burst) push_random();
      drain();
      check_flag("overflow_o", overflow_o, 1'b0);
    end

    // One go more than the queue holds while the unpacker is stalled
    gnt_hold = 1'b1;
    repeat (`CMD_FIFO_DEPTH + 1) push_random();
    tick(1'b0, 2'd0, 32'd0);
    tick(1'b0, 2'd0, 32'd0);
    check_flag("overflow_o", overflow_o, 1'b1);
    gnt_hold = 1'b0;
    drain();

    // Dropped command must never show up
    repeat (20) tick(1'b0, 2'd0, 32'd0);
    check_flag("overflow_o", overflow_o, 1'b1);
    check_flag("busy_o", busy_o, 1'b0);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- dv/tcdm_dma_assertions.sv
//**************************************************************************
// Protocol assertions on the command unpacker
// Bound into every tcdm_cmd_unpack instance
//**************************************************************************

module tcdm_dma_assertions (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       cmd_valid_i,
  input logic       cmd_pop_i,
  input logic [1:0] gnt_i,
  input logic [1:0] req_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Request only in a cycle where both ports grant
  req_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|req_i) |-> (&gnt_i))
    else $error("beat request without both grants");

  // Both ports always move together
  req_paired: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i[0] == req_i[1])
    else $error("port requests differ");

  // Queue head popped only when present
  pop_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_pop_i |-> cmd_valid_i)
    else $error("command pop from an empty queue");

endmodule

bind tcdm_cmd_unpack tcdm_dma_assertions u_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .cmd_valid_i (cmd_valid_i),
  .cmd_pop_i   (cmd_pop_o),
  .gnt_i       (beat_gnt_i),
  .req_i       (beat_req_o)
);

//--- hw/tcdm_cmd_fifo.sv
//**************************************************************************
// Command queue between the register block and the unpacker
// Circular buffer, head is shown while valid_o is high, pop advances it
//**************************************************************************

`include "tcdm_dma_macros.svh"

module tcdm_cmd_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    push_i,
  input  tcdm_dma_pkg::tcdm_cmd_t cmd_i,
  input  logic                    pop_i,
  output tcdm_dma_pkg::tcdm_cmd_t cmd_o,
  output logic                    valid_o,
  output logic                    full_o
);

  localparam int unsigned PtrWidth = $clog2(`CMD_FIFO_DEPTH);

  // Entry storage
  tcdm_dma_pkg::tcdm_cmd_t mem_q [`CMD_FIFO_DEPTH];

  // Read and write pointers, fill count one bit wider
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth:0]   count_q;

  // Storage write, caller checks full
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

  //**************************************************************************
  // Pointers and fill level
  //**************************************************************************

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        // Wrap at the last entry
        if (wr_ptr_q == PtrWidth'(`CMD_FIFO_DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop_i) begin
        if (rd_ptr_q == PtrWidth'(`CMD_FIFO_DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Simultaneous push and pop keep the level
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign cmd_o   = mem_q[rd_ptr_q];
  assign valid_o = (count_q != '0);
  assign full_o  = (count_q == (PtrWidth + 1)'(`CMD_FIFO_DEPTH));

endmodule

//--- hw/tcdm_cmd_regs.sv
//**************************************************************************
// Command staging registers of the DMA
// Software writes address, length, opcode and sid, then go pushes the
// staged command into the queue, a push into a full queue is dropped
//**************************************************************************

`include "tcdm_dma_macros.svh"

module tcdm_cmd_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    reg_we_i,
  input  logic [1:0]              reg_addr_i,
  input  logic [31:0]             reg_wdata_i,
  input  logic                    fifo_full_i,
  output logic                    push_o,
  output tcdm_dma_pkg::tcdm_cmd_t cmd_o,
  output logic                    overflow_o
);

  // Staged command, kept across gos
  tcdm_dma_pkg::tcdm_cmd_t cmd_q;
  // Go seen at the previous edge
  logic                    go_q;
  logic                    overflow_q;

  // Register writes, one field per address
  always_ff @(posedge clk_i) begin
    if (reg_we_i) begin
      case (reg_addr_i)
        2'd0: cmd_q.add <= reg_wdata_i[`TCDM_ADD_WIDTH-1:0];
        2'd1: cmd_q.len <= reg_wdata_i[`TCDM_LEN_WIDTH-1:0];
        2'd2: begin
          cmd_q.opc <= reg_wdata_i[`TCDM_OPC_WIDTH-1:0];
          cmd_q.sid <= reg_wdata_i[16 +: `TRANS_SID_WIDTH];
        end
        default: ;
      endcase
    end
  end

  // Go strobe and sticky overflow
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      go_q       <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      go_q <= reg_we_i && (reg_addr_i == 2'd3);
      // Full queue at push time drops the command
      if (go_q && fifo_full_i) begin
        overflow_q <= 1'b1;
      end
    end
  end

  assign push_o     = go_q && !fifo_full_i;
  assign cmd_o      = cmd_q;
  assign overflow_o = overflow_q;

endmodule

//--- hw/tcdm_cmd_unpack/tcdm_cmd_unpack.sv
//**************************************************************************
// Splits one DMA command into 8-byte aligned beats on two 32-bit ports
// A beat goes out only in a cycle where both ports grant, the first
// beat comes straight from the queue head with no added latency
//**************************************************************************

`include "tcdm_dma_macros.svh"

module tcdm_cmd_unpack (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  tcdm_dma_pkg::tcdm_cmd_t        cmd_i,
  input  logic                           cmd_valid_i,
  output logic                           cmd_pop_o,
  input  logic [1:0]                     beat_gnt_i,
  output logic [1:0]                     beat_req_o,
  output tcdm_dma_pkg::tcdm_beat_t [1:0] beat_o,
  output logic                           busy_o
);

  typedef enum logic {
    idle_st,
    run_st
  } state_e;

  state_e state_q, state_d;

  // Both ports free in this cycle
  logic both_gnt;

  // Start offset plus length, one bit wider than the length
  logic [`TCDM_LEN_WIDTH:0]   span;
  logic [`BEAT_CNT_WIDTH-1:0] beats_nb;

  // Running command, address kept 8-aligned
  logic [`TCDM_ADD_WIDTH-1:0]  add_q;
  logic [`TCDM_OPC_WIDTH-1:0]  opc_q;
  logic [`TRANS_SID_WIDTH-1:0] sid_q;
  logic [`BEAT_CNT_WIDTH-1:0]  beats_left_q;

  // Current beat
  logic                        issue;
  logic                        last;
  logic [`TCDM_ADD_WIDTH-1:0]  beat_add;
  logic [`TCDM_ADD_WIDTH-1:0]  beat_aligned;
  logic [`TCDM_OPC_WIDTH-1:0]  beat_opc;
  logic [`TRANS_SID_WIDTH-1:0] beat_sid;

  assign both_gnt = &beat_gnt_i;

  //**************************************************************************
  // Beat count of the head command
  //**************************************************************************

  // Beats = ((add mod 8) + len) / 8 + 1
  assign span     = {{(`TCDM_LEN_WIDTH - 2){1'b0}}, cmd_i.add[2:0]} + {1'b0, cmd_i.len};
  assign beats_nb = span[`TCDM_LEN_WIDTH:3] + `BEAT_CNT_WIDTH'(1);

  //**************************************************************************
  // Control
  //**************************************************************************

  always_comb begin
    state_d   = state_q;
    issue     = 1'b0;
    last      = 1'b0;
    cmd_pop_o = 1'b0;
    beat_add  = cmd_i.add;
    beat_opc  = cmd_i.opc;
    beat_sid  = cmd_i.sid;

    case (state_q)
      idle_st: begin
        // First beat taken straight from the head
        if (cmd_valid_i && both_gnt) begin
          issue     = 1'b1;
          cmd_pop_o = 1'b1;
          if (beats_nb == `BEAT_CNT_WIDTH'(1)) begin
            last = 1'b1;
          end else begin
            state_d = run_st;
          end
        end
      end
      run_st: begin
        beat_add = add_q;
        beat_opc = opc_q;
        beat_sid = sid_q;
        // Missing grant stalls, nothing issued
        if (both_gnt) begin
          issue = 1'b1;
          if (beats_left_q == `BEAT_CNT_WIDTH'(1)) begin
            last    = 1'b1;
            state_d = idle_st;
          end
        end
      end
      default: state_d = idle_st;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= idle_st;
      beats_left_q <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_pop_o) begin
        // Beats still due after the first one
        beats_left_q <= beats_nb - `BEAT_CNT_WIDTH'(1);
      end else if (issue) begin
        beats_left_q <= beats_left_q - `BEAT_CNT_WIDTH'(1);
      end
    end
  end

  //**************************************************************************
  // Address walk and command fields
  //**************************************************************************

  always_ff @(posedge clk_i) begin
    if (cmd_pop_o) begin
      add_q <= beat_aligned + `TCDM_ADD_WIDTH'(8);
      opc_q <= cmd_i.opc;
      sid_q <= cmd_i.sid;
    end else if (issue) begin
      add_q <= add_q + `TCDM_ADD_WIDTH'(8);
    end
  end

  // Low 3 bits dropped, port 1 takes the upper word
  assign beat_aligned = {beat_add[`TCDM_ADD_WIDTH-1:3], 3'b000};

  assign beat_o[0] = '{opc: beat_opc, add: beat_aligned, sid: beat_sid, eop: last};
  assign beat_o[1] = '{opc: beat_opc,
                       add: beat_aligned + `TCDM_ADD_WIDTH'(4),
                       sid: beat_sid,
                       eop: last};

  assign beat_req_o = {2{issue}};
  assign busy_o     = (state_q == run_st);

endmodule

//--- hw/tcdm_dma_top.sv
//**************************************************************************
// Command side of the TCDM DMA
// Register block feeds the command queue, the unpacker drains it into
// dual-port beats under TCDM grant
//**************************************************************************

module tcdm_dma_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           reg_we_i,
  input  logic [1:0]                     reg_addr_i,
  input  logic [31:0]                    reg_wdata_i,
  input  logic [1:0]                     beat_gnt_i,
  output logic [1:0]                     beat_req_o,
  output tcdm_dma_pkg::tcdm_beat_t [1:0] beat_o,
  output logic                           overflow_o,
  output logic                           busy_o
);

  // Register block to queue
  logic                    push;
  logic                    fifo_full;
  tcdm_dma_pkg::tcdm_cmd_t push_cmd;

  // Queue to unpacker
  logic                    cmd_valid;
  logic                    cmd_pop;
  tcdm_dma_pkg::tcdm_cmd_t head_cmd;

  tcdm_cmd_regs u_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .fifo_full_i (fifo_full),
    .push_o      (push),
    .cmd_o       (push_cmd),
    .overflow_o  (overflow_o)
  );

  tcdm_cmd_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .cmd_i   (push_cmd),
    .pop_i   (cmd_pop),
    .cmd_o   (head_cmd),
    .valid_o (cmd_valid),
    .full_o  (fifo_full)
  );

  tcdm_cmd_unpack u_unpack (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (head_cmd),
    .cmd_valid_i (cmd_valid),
    .cmd_pop_o   (cmd_pop),
    .beat_gnt_i  (beat_gnt_i),
    .beat_req_o  (beat_req_o),
    .beat_o      (beat_o),
    .busy_o      (busy_o)
  );

endmodule
